/* ixu_pkg.sv */
// ==================================================
// Integer execution cluster shared definitions
// Sizes of the pack, ROB, register and queue spaces
// ALU opcode enum
// Payload, dispatch, issue and writeback structs
// ==================================================
package ixu_pkg;

  // Sixteen packs in flight, each pack holds up to two instructions
  localparam int NUM_PACKS = 16;
  localparam int PACK_W = 4;

  // A ROB id is the pack id with the slot bit appended below it
  localparam int ROB_W = PACK_W + 1;

  // Physical register space seen by the cluster
  localparam int NUM_PREGS = 64;
  localparam int PREG_W = 6;

  // Issue queue depth
  localparam int IQ_DEPTH = 8;

  // ALU operations
  // Shifts take their amount from the low five bits of operand two
  // LUI places operand two twelve bits up
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    SLL = 4'd5,
    SRL = 4'd6,
    SLT = 4'd7,
    LUI = 4'd8
  } alu_op_e;

  // Static fields of one instruction, kept in the payload RAM until it issues
  typedef struct packed {
    alu_op_e           opcode;
    logic              use_imm;
    logic [31:0]       immediate;
    logic [PREG_W-1:0] dest;
  } ins_payload_t;

  // One slot of a dispatch pack
  // The sources only go to the issue queue, the payload goes to the RAM
  typedef struct packed {
    logic              valid;
    ins_payload_t      payload;
    logic [PREG_W-1:0] src1;
    logic [PREG_W-1:0] src2;
  } dispatch_slot_t;

  // Slot 0 is the older instruction of the pack
  typedef struct packed {
    dispatch_slot_t [1:0] slot;
    logic [PACK_W-1:0]    pack_id;
  } dispatch_pack_t;

  // One instruction picked for execution this cycle
  // Also used as the entry format inside the issue queue
  typedef struct packed {
    logic              valid;
    logic [ROB_W-1:0]  rob_id;
    logic [PREG_W-1:0] src1;
    logic [PREG_W-1:0] src2;
  } issue_t;

  // Registered ALU result heading for the register file
  typedef struct packed {
    logic              valid;
    logic [ROB_W-1:0]  rob_id;
    logic [PREG_W-1:0] dest;
    logic [31:0]       result;
  } wb_t;

endpackage

/* ixu_iram.sv */
// ==================================================
// Instruction payload RAM
// One bank per dispatch slot, rows indexed by pack id
// Two asynchronous read ports addressed by ROB id
// ==================================================
`timescale 1ns/1ps

module ixu_iram (
  input  logic                         cpu_clk_i,
  input  ixu_pkg::dispatch_pack_t      wr_pack_i,
  input  logic                         wr_en_i,
  input  logic [ixu_pkg::ROB_W-1:0]    rd0_rob_i,
  input  logic [ixu_pkg::ROB_W-1:0]    rd1_rob_i,
  output ixu_pkg::ins_payload_t        rd0_payload_o,
  output ixu_pkg::ins_payload_t        rd1_payload_o
);
  import ixu_pkg::*;

  // Bank index is the slot bit, row index is the pack id
  ins_payload_t ram [2][NUM_PACKS];

  // Both slots of an accepted pack land in the same row of their own bank
  // An invalid slot leaves its row untouched
  always_ff @(posedge cpu_clk_i) begin
    for (int s = 0; s < 2; s++) begin
      if (wr_en_i && wr_pack_i.slot[s].valid) begin
        ram[s][wr_pack_i.pack_id] <= wr_pack_i.slot[s].payload;
      end
    end
  end

  // The low ROB bit picks the bank, the upper bits are the pack id
  assign rd0_payload_o = ram[rd0_rob_i[0]][rd0_rob_i[ROB_W-1:1]];
  assign rd1_payload_o = ram[rd1_rob_i[0]][rd1_rob_i[ROB_W-1:1]];

endmodule

/* ixu_issue_queue.sv */
// ==================================================
// Collapsing issue queue with register ready table
// Entries stay in age order by position
// Picks the two oldest ready entries every cycle
// ==================================================
`timescale 1ns/1ps

module ixu_issue_queue (
  input  logic                    cpu_clk_i,
  input  logic                    rst_i,
  input  ixu_pkg::dispatch_pack_t disp_i,
  input  logic                    disp_valid_i,
  output logic                    disp_ready_o,
  input  ixu_pkg::wb_t            wb0_i,
  input  ixu_pkg::wb_t            wb1_i,
  output ixu_pkg::issue_t         issue0_o,
  output ixu_pkg::issue_t         issue1_o
);
  import ixu_pkg::*;

  // Position 0 holds the oldest entry, valid entries are contiguous from 0
  issue_t q [IQ_DEPTH];
  issue_t q_n [IQ_DEPTH];

  // One bit per physical register, set once its value is in the register file
  logic [NUM_PREGS-1:0] rdy_tbl;
  logic [NUM_PREGS-1:0] rdy_tbl_n;

  logic [IQ_DEPTH-1:0] ent_rdy;
  logic [IQ_DEPTH-1:0] pick;
  logic [3:0]          q_count;
  logic                accept;

  // Occupancy before this cycle's issues, so a full pack always fits
  always_comb begin
    q_count = '0;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      q_count = q_count + {3'd0, q[i].valid};
    end
  end

  assign disp_ready_o = (q_count <= 4'(IQ_DEPTH - 2));
  assign accept = disp_valid_i & disp_ready_o;

  // An entry may go once both of its sources have been written back
  always_comb begin
    for (int i = 0; i < IQ_DEPTH; i++) begin
      ent_rdy[i] = q[i].valid & rdy_tbl[q[i].src1] & rdy_tbl[q[i].src2];
    end
  end

  // Scan from the oldest position and take the first two ready entries
  always_comb begin
    issue0_o = '0;
    issue1_o = '0;
    pick = '0;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      if (ent_rdy[i]) begin
        if (!issue0_o.valid) begin
          issue0_o = q[i];
          pick[i] = 1'b1;
        end else if (!issue1_o.valid) begin
          issue1_o = q[i];
          pick[i] = 1'b1;
        end
      end
    end
  end

  // Survivors slide down over the issued holes, then new slots go behind them
  always_comb begin
    logic [3:0] wp;
    wp = '0;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      q_n[i] = '0;
    end
    for (int i = 0; i < IQ_DEPTH; i++) begin
      if (q[i].valid && !pick[i]) begin
        q_n[wp[2:0]] = q[i];
        wp = wp + 4'd1;
      end
    end
    // Slot 0 is older than slot 1, so it is appended first
    for (int s = 0; s < 2; s++) begin
      if (accept && disp_i.slot[s].valid && wp < 4'(IQ_DEPTH)) begin
        q_n[wp[2:0]].valid = 1'b1;
        q_n[wp[2:0]].rob_id = {disp_i.pack_id, 1'(s)};
        q_n[wp[2:0]].src1 = disp_i.slot[s].src1;
        q_n[wp[2:0]].src2 = disp_i.slot[s].src2;
        wp = wp + 4'd1;
      end
    end
  end

  // Writeback marks a register ready, dispatch of a new producer clears it
  // The clear is applied last so it wins on the same register
  always_comb begin
    rdy_tbl_n = rdy_tbl;
    if (wb0_i.valid) begin
      rdy_tbl_n[wb0_i.dest] = 1'b1;
    end
    if (wb1_i.valid) begin
      rdy_tbl_n[wb1_i.dest] = 1'b1;
    end
    for (int s = 0; s < 2; s++) begin
      if (accept && disp_i.slot[s].valid) begin
        rdy_tbl_n[disp_i.slot[s].payload.dest] = 1'b0;
      end
    end
  end

  // All registers hold zero after reset, so all of them start ready
  always_ff @(posedge cpu_clk_i) begin
    if (rst_i) begin
      rdy_tbl <= '1;
      for (int i = 0; i < IQ_DEPTH; i++) begin
        q[i] <= '0;
      end
    end else begin
      rdy_tbl <= rdy_tbl_n;
      q <= q_n;
    end
  end

endmodule

/* ixu_regfile.sv */
// ==================================================
// Physical register file, 64 entries of 32 bits
// Four asynchronous read ports, two writeback ports
// ==================================================
`timescale 1ns/1ps

module ixu_regfile (
  input  logic                       cpu_clk_i,
  input  logic                       rst_i,
  input  logic [ixu_pkg::PREG_W-1:0] rd_addr0_i,
  input  logic [ixu_pkg::PREG_W-1:0] rd_addr1_i,
  input  logic [ixu_pkg::PREG_W-1:0] rd_addr2_i,
  input  logic [ixu_pkg::PREG_W-1:0] rd_addr3_i,
  output logic [31:0]                rd_data0_o,
  output logic [31:0]                rd_data1_o,
  output logic [31:0]                rd_data2_o,
  output logic [31:0]                rd_data3_o,
  input  ixu_pkg::wb_t               wb0_i,
  input  ixu_pkg::wb_t               wb1_i
);
  import ixu_pkg::*;

  logic [31:0] regs [NUM_PREGS];

  // Renaming never hands the same destination to two live instructions,
  // so the two writeback ports do not collide
  always_ff @(posedge cpu_clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_PREGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb0_i.valid) begin
        regs[wb0_i.dest] <= wb0_i.result;
      end
      if (wb1_i.valid) begin
        regs[wb1_i.dest] <= wb1_i.result;
      end
    end
  end

  // No bypass, a value becomes visible the cycle after its writeback
  assign rd_data0_o = regs[rd_addr0_i];
  assign rd_data1_o = regs[rd_addr1_i];
  assign rd_data2_o = regs[rd_addr2_i];
  assign rd_data3_o = regs[rd_addr3_i];

endmodule

/* ixu_alu.sv */
// ==================================================
// Single-cycle integer ALU
// Operand select, opcode evaluation
// Registered writeback with ROB id and destination
// ==================================================
`timescale 1ns/1ps

module ixu_alu (
  input  logic                  cpu_clk_i,
  input  logic                  rst_i,
  input  ixu_pkg::issue_t       issue_i,
  input  ixu_pkg::ins_payload_t payload_i,
  input  logic [31:0]           op1_i,
  input  logic [31:0]           op2_i,
  output ixu_pkg::wb_t          wb_o
);
  import ixu_pkg::*;

  logic [31:0] op2_sel;
  logic [4:0]  shamt;
  logic [31:0] result;

  // Writeback stage registers
  logic              wb_valid_q;
  logic [ROB_W-1:0]  wb_rob_q;
  logic [PREG_W-1:0] wb_dest_q;
  logic [31:0]       wb_result_q;

  // Immediate forms replace the second register operand
  assign op2_sel = payload_i.use_imm ? payload_i.immediate : op2_i;
  assign shamt = op2_sel[4:0];

  always_comb begin
    case (payload_i.opcode)
      ADD: result = op1_i + op2_sel;
      SUB: result = op1_i - op2_sel;
      AND: result = op1_i & op2_sel;
      OR:  result = op1_i | op2_sel;
      XOR: result = op1_i ^ op2_sel;
      SLL: result = op1_i << shamt;
      SRL: result = op1_i >> shamt;
      // Signed compare gives 0 or 1
      SLT: result = {31'd0, $signed(op1_i) < $signed(op2_sel)};
      // Upper immediate ignores operand one entirely
      LUI: result = op2_sel << 12;
      default: result = '0;
    endcase
  end

  // Writeback valid trails the issue valid by one cycle
  always_ff @(posedge cpu_clk_i) begin
    if (rst_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= issue_i.valid;
    end
  end

  // ROB id, destination and result of the issued instruction
  always_ff @(posedge cpu_clk_i) begin
    wb_rob_q <= issue_i.rob_id;
    wb_dest_q <= payload_i.dest;
    wb_result_q <= result;
  end

  assign wb_o.valid = wb_valid_q;
  assign wb_o.rob_id = wb_rob_q;
  assign wb_o.dest = wb_dest_q;
  assign wb_o.result = wb_result_q;

endmodule

/* ixu_top.sv */
// ==================================================
// Integer execution cluster top level
// Issue queue, payload RAM, register file, two ALUs
// ==================================================
`timescale 1ns/1ps

module ixu_top (
  input  logic                    cpu_clk_i,
  input  logic                    rst_i,
  input  ixu_pkg::dispatch_pack_t dispatch_i,
  input  logic                    dispatch_valid_i,
  output logic                    dispatch_ready_o,
  output ixu_pkg::wb_t            wb0_o,
  output ixu_pkg::wb_t            wb1_o
);
  import ixu_pkg::*;

  issue_t       issue0;
  issue_t       issue1;
  ins_payload_t payload0;
  ins_payload_t payload1;
  logic [31:0]  rf_data0;
  logic [31:0]  rf_data1;
  logic [31:0]  rf_data2;
  logic [31:0]  rf_data3;
  logic         disp_accept;

  // Handshake completes when the queue has room for a whole pack
  assign disp_accept = dispatch_valid_i & dispatch_ready_o;

  // Writebacks loop back to wake up waiting entries
  ixu_issue_queue u_iq (
    .cpu_clk_i    (cpu_clk_i),
    .rst_i        (rst_i),
    .disp_i       (dispatch_i),
    .disp_valid_i (dispatch_valid_i),
    .disp_ready_o (dispatch_ready_o),
    .wb0_i        (wb0_o),
    .wb1_i        (wb1_o),
    .issue0_o     (issue0),
    .issue1_o     (issue1)
  );

  // Static fields come back by ROB id in the issue cycle
  ixu_iram u_iram (
    .cpu_clk_i     (cpu_clk_i),
    .wr_pack_i     (dispatch_i),
    .wr_en_i       (disp_accept),
    .rd0_rob_i     (issue0.rob_id),
    .rd1_rob_i     (issue1.rob_id),
    .rd0_payload_o (payload0),
    .rd1_payload_o (payload1)
  );

  // Ports 0 and 1 serve ALU0, ports 2 and 3 serve ALU1
  ixu_regfile u_rf (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .rd_addr0_i (issue0.src1),
    .rd_addr1_i (issue0.src2),
    .rd_addr2_i (issue1.src1),
    .rd_addr3_i (issue1.src2),
    .rd_data0_o (rf_data0),
    .rd_data1_o (rf_data1),
    .rd_data2_o (rf_data2),
    .rd_data3_o (rf_data3),
    .wb0_i      (wb0_o),
    .wb1_i      (wb1_o)
  );

  // The oldest ready instruction always goes to ALU0
  ixu_alu u_alu0 (
    .cpu_clk_i (cpu_clk_i),
    .rst_i     (rst_i),
    .issue_i   (issue0),
    .payload_i (payload0),
    .op1_i     (rf_data0),
    .op2_i     (rf_data1),
    .wb_o      (wb0_o)
  );

  ixu_alu u_alu1 (
    .cpu_clk_i (cpu_clk_i),
    .rst_i     (rst_i),
    .issue_i   (issue1),
    .payload_i (payload1),
    .op1_i     (rf_data2),
    .op2_i     (rf_data3),
    .wb_o      (wb1_o)
  );

endmodule

/* ixu_checker.sv */
// ==================================================
// Writeback monitor for the execution cluster
// Expected results per ROB id, idle checks
// Dispatch back-pressure seen during the burst
// ==================================================
`timescale 1ns/1ps

module ixu_checker (
  input  logic         cpu_clk_i,
  input  logic         rst_i,
  input  logic         dispatch_valid_i,
  input  logic         dispatch_ready_i,
  input  ixu_pkg::wb_t wb0_i,
  input  ixu_pkg::wb_t wb1_i,
  output int           err_cnt_o,
  output int           pending_o
);
  import ixu_pkg::*;

  logic [31:0] vec [512];
  // Expected {dest, result} in completion order, one queue per ROB id
  logic [37:0] exp_q [32][$];
  logic        started;
  logic        ready_low_seen;
  logic        burst_reported;
  int          errs;

  initial begin
    errs = 0;
    started = 1'b0;
    ready_low_seen = 1'b0;
    burst_reported = 1'b0;
    $readmemh("ixu_vectors.txt", vec);
    for (int r = 0; r < 56 && vec[r*9] !== 32'hff; r++) begin
      if (vec[r*9+1][0]) begin
        exp_q[vec[r*9][4:0]].push_back({vec[r*9+5][5:0], vec[r*9+8]});
      end
    end
  end

  task automatic check_wb(input wb_t wb, input string name);
    logic [37:0] e;
    if (exp_q[wb.rob_id].size() == 0) begin
      $display("%0t: ROB id %0d completed more often than expected on %s",
               $time, wb.rob_id, name);
      errs++;
    end else begin
      e = exp_q[wb.rob_id].pop_front();
      if (wb.result !== e[31:0]) begin
        $display("[ERROR] %0t %s.result expected %h got %h", $time, name, e[31:0], wb.result);
        errs++;
      end
      if (wb.dest !== e[37:32]) begin
        $display("[ERROR] %0t %s.dest expected %h got %h", $time, name, e[37:32], wb.dest);
        errs++;
      end
    end
  endtask

  // Nothing may happen before the first dispatch
  always @(posedge cpu_clk_i) begin
    if (!rst_i && dispatch_valid_i) begin
      started <= 1'b1;
    end
  end

  // Writebacks are registered, so the falling edge sees them settled
  always @(negedge cpu_clk_i) begin
    if (!rst_i && !started) begin
      if (!dispatch_ready_i) begin
        $display("%0t: dispatch ready is low on an empty cluster", $time);
        errs++;
      end
      if (wb0_i.valid || wb1_i.valid) begin
        $display("%0t: writeback seen before any dispatch", $time);
        errs++;
      end
    end else if (!rst_i) begin
      if (!dispatch_ready_i) begin
        ready_low_seen = 1'b1;
      end
      if (wb0_i.valid) check_wb(wb0_i, "wb0_o");
      if (wb1_i.valid) check_wb(wb1_i, "wb1_o");
    end
    pending_o = 0;
    for (int i = 0; i < 32; i++) begin
      pending_o += exp_q[i].size();
    end
    // The dependent burst must push the queue past its dispatch threshold
    if (started && pending_o == 0 && !ready_low_seen && !burst_reported) begin
      $display("%0t: dispatch ready never dropped during the burst", $time);
      errs++;
      burst_reported = 1'b1;
    end
  end

  assign err_cnt_o = errs;

endmodule

/* tb_ixu.sv */
// ==================================================
// Testbench top for the execution cluster
// Clock, reset, DUT, vector-driven dispatch driver
// ==================================================
`timescale 1ns/1ps

module tb_ixu;
  import ixu_pkg::*;

  localparam int TIMEOUT = 2000;

  logic           cpu_clk_i;
  logic           rst_i;
  logic           dispatch_valid_i;
  logic           dispatch_ready_o;
  dispatch_pack_t dispatch_i;
  wb_t            wb0_o;
  wb_t            wb1_o;
  logic [31:0]    vec [512];
  int             err_cnt;
  int             pending;
  int             sent [32];
  int             done [32];

  ixu_top ixu_top_i (
    .cpu_clk_i        (cpu_clk_i),
    .rst_i            (rst_i),
    .dispatch_i       (dispatch_i),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_ready_o (dispatch_ready_o),
    .wb0_o            (wb0_o),
    .wb1_o            (wb1_o)
  );

  ixu_checker u_checker (
    .cpu_clk_i        (cpu_clk_i),
    .rst_i            (rst_i),
    .dispatch_valid_i (dispatch_valid_i),
    .dispatch_ready_i (dispatch_ready_o),
    .wb0_i            (wb0_o),
    .wb1_i            (wb1_o),
    .err_cnt_o        (err_cnt),
    .pending_o        (pending)
  );

  initial begin
    cpu_clk_i = 1'b0;
    forever #4 cpu_clk_i = ~cpu_clk_i;
  end

  // Completions per ROB id, used to hold back pack id reuse
  always @(negedge cpu_clk_i) begin
    if (wb0_o.valid) done[wb0_o.rob_id]++;
    if (wb1_o.valid) done[wb1_o.rob_id]++;
  end

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic send_pack(input int r);
    dispatch_pack_t p;
    int             t;
    int             b;
    p = '0;
    p.pack_id = vec[r*9][4:1];
    for (int s = 0; s < 2; s++) begin
      b = (r + s) * 9;
      p.slot[s].valid = vec[b+1][0];
      p.slot[s].payload.opcode = alu_op_e'(vec[b+2][3:0]);
      p.slot[s].payload.use_imm = vec[b+3][0];
      p.slot[s].payload.immediate = vec[b+4];
      p.slot[s].payload.dest = vec[b+5][5:0];
      p.slot[s].src1 = vec[b+6][5:0];
      p.slot[s].src2 = vec[b+7][5:0];
    end
    t = 0;
    while (sent[{p.pack_id, 1'b0}] != done[{p.pack_id, 1'b0}] ||
           sent[{p.pack_id, 1'b1}] != done[{p.pack_id, 1'b1}]) begin
      @(negedge cpu_clk_i);
      t++;
      if (t > TIMEOUT) abort_run("pack id never drained before reuse");
    end
    dispatch_i = p;
    dispatch_valid_i = 1'b1;
    // Ready only moves at the rising edge, so the falling edge value holds
    t = 0;
    while (!dispatch_ready_o) begin
      @(negedge cpu_clk_i);
      t++;
      if (t > TIMEOUT) abort_run("dispatch ready stayed low");
    end
    @(negedge cpu_clk_i);
    for (int s = 0; s < 2; s++) begin
      if (p.slot[s].valid) sent[{p.pack_id, 1'(s)}]++;
    end
  endtask

  initial begin
    int r;
    int t;
    rst_i = 1'b1;
    dispatch_valid_i = 1'b0;
    dispatch_i = '0;
    $readmemh("ixu_vectors.txt", vec);
    repeat (10) @(posedge cpu_clk_i);
    @(negedge cpu_clk_i);
    rst_i = 1'b0;
    // Idle window for the post-reset checks
    repeat (5) @(negedge cpu_clk_i);
    r = 0;
    while (r < 56 && vec[r*9] !== 32'hff) begin
      send_pack(r);
      r += 2;
    end
    dispatch_valid_i = 1'b0;
    t = 0;
    while (pending != 0) begin
      @(negedge cpu_clk_i);
      t++;
      if (t > TIMEOUT) abort_run($sformatf("%0d ROB ids never completed", pending));
    end
    // Extra cycles catch any duplicate completion
    repeat (10) @(negedge cpu_clk_i);
    $display("Checks done: %0d errors, %0d results outstanding", err_cnt, pending);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* ixu_vectors.txt */
// rob valid op use_imm imm dest src1 src2 expected (hex); rob ff ends the list
// two lines per pack, slot 0 then slot 1; ops 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt 8 lui
00 1 8 1 00000012 01 00 00 00012000
01 1 0 1 00000345 02 00 00 00000345
02 1 0 1 fffffffb 03 00 00 fffffffb
03 1 0 1 00000007 04 00 00 00000007
04 1 0 0 00000000 05 01 02 00012345
05 1 1 0 00000000 06 05 04 0001233e
06 1 2 0 00000000 07 05 06 00012304
07 1 3 0 00000000 08 05 04 00012347
08 1 4 0 00000000 09 05 06 0000007b
09 1 5 0 00000000 0a 04 03 38000000
0a 1 6 0 00000000 0b 03 04 01ffffff
0b 1 7 0 00000000 0c 03 04 00000001
0c 1 7 0 00000000 0d 04 03 00000000
0d 1 7 0 00000000 0e 03 0a 00000001
0e 1 0 0 00000000 0f 07 08 0002464b
0f 0 0 0 00000000 00 00 00 00000000
10 1 0 1 00000001 10 0f 00 0002464c
11 1 0 0 00000000 11 10 10 00048c98
12 1 1 0 00000000 12 11 0f 0002464d
13 0 0 0 00000000 00 00 00 00000000
14 1 0 0 00000000 13 12 12 00048c9a
15 1 0 0 00000000 14 13 13 00091934
16 1 0 0 00000000 15 14 14 00123268
17 1 0 0 00000000 16 15 15 002464d0
18 1 0 0 00000000 17 16 16 0048c9a0
19 1 4 0 00000000 18 17 15 005afbc8
ff 0 0 0 00000000 00 00 00 00000000

/* filelist.f */
ixu_pkg.sv
ixu_iram.sv
ixu_issue_queue.sv
ixu_regfile.sv
ixu_alu.sv
ixu_top.sv
ixu_checker.sv
tb_ixu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f filelist.f --top-module tb_ixu -o sim_ixu
./obj_dir/sim_ixu > sim.log 2>&1 || true
cat sim.log
if grep -q '^>>> PASS$' sim.log; then
  exit 0
fi
exit 1
